//--- project.f
+incdir+include
hdl/bridge_pkg.sv
hdl/addr_decode.sv
hdl/target_port.sv
hdl/initiator_port.sv
hdl/bus_bridge.sv
tb/tb_bus_bridge.sv

//--- Makefile
TOP = tb_bus_bridge

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -j 0 --top-module $(TOP) -f project.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

//--- tb/tb_bus_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_cfg.svh"

module tb_bus_bridge;

    localparam int TIMEOUT = 64;
    // the bus A strobe shows in sample 1, the accept and a miss ack two cycles later
    localparam int ACCEPT_SAMPLE = 3;
    localparam int LATE_SAMPLE   = 4;

    typedef struct packed {
        bridge_pkg::addr_t a_addr;
        logic              rw;
        bridge_pkg::data_t wdata;
        logic              late;
        bridge_pkg::addr_t b_addr;
        logic              hit;
        logic              split;
    } row_t;

    logic              clk = 1'b0;
    logic              rst_n;
    bridge_pkg::addr_t target_addr_in;
    logic              target_addr_in_valid;
    logic              target_rw;
    bridge_pkg::data_t target_data_in;
    logic              target_data_in_valid;
    logic              split_grant;
    logic              target_split_ack;
    logic              target_ack;
    bridge_pkg::data_t target_data_out;
    logic              target_data_out_valid;
    logic              split_req;
    logic              init_req;
    bridge_pkg::addr_t init_addr_out;
    logic              init_addr_out_valid;
    bridge_pkg::data_t init_data_out;
    logic              init_data_out_valid;
    logic              init_rw;
    logic              init_grant;
    bridge_pkg::data_t init_data_in;
    logic              init_data_in_valid;
    logic              init_ack;
    logic              init_split_ack;

    row_t              rows[$];
    bridge_pkg::data_t mem [0:65535];
    bit                written [0:65535];
    integer            seed = 21779;
    int                errors;
    int                ok_count;
    int                bad_count;
    bit                timed_out;

    // what the bus B responder saw at the last grant
    int                b_count;
    bridge_pkg::addr_t b_addr;
    logic              b_rw;
    bridge_pkg::data_t b_data;
    logic              b_addr_valid_held;
    logic              b_data_valid;
    logic              b_req_held;
    int                data_first_count;
    int                ack_first_count;

    bus_bridge i_dut (.*);

    always #5 clk = ~clk;

    // unwritten bus B bytes follow the whole address
    function automatic bridge_pkg::data_t fill_byte(input bridge_pkg::addr_t a);
        return a[7:0] ^ a[15:8] ^ 8'h5A;
    endfunction

    function automatic row_t make_row(input bridge_pkg::addr_t a, input logic rw,
                                      input bridge_pkg::data_t d, input logic late);
        row_t r;
        int   off;
        int   r0;
        int   r1;
        int   r2;
        r0 = int'(`REGION0_SIZE);
        r1 = int'(`REGION1_SIZE);
        r2 = int'(`REGION2_SIZE);
        off = int'(a) - int'(`BRIDGE_BASE_ADDR);
        r = '0;
        r.a_addr = a;
        r.rw = rw;
        r.wdata = d;
        r.late = late;
        r.hit = (off >= 0) && (off < r0 + r1 + r2);
        r.split = (off >= 0) && (off < r0);
        if (r.split) begin
            r.b_addr = bridge_pkg::addr_t'(int'(`REGION0_B_BASE) + off);
        end else if (r.hit && off < r0 + r1) begin
            r.b_addr = bridge_pkg::addr_t'(int'(`REGION1_B_BASE) + off - r0);
        end else if (r.hit) begin
            r.b_addr = bridge_pkg::addr_t'(int'(`REGION2_B_BASE) + off - r0 - r1);
        end
        return r;
    endfunction

    // the last earlier write to the same bus B byte wins
    function automatic bridge_pkg::data_t expected_read(input int idx);
        bridge_pkg::data_t d;
        d = fill_byte(rows[idx].b_addr);
        for (int j = 0; j < idx; j++) begin
            if (rows[j].hit && rows[j].rw && rows[j].b_addr == rows[idx].b_addr) begin
                d = rows[j].wdata;
            end
        end
        return d;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string what, input int err_before);
        if (errors == err_before) begin
            ok_count++;
            $display("%s: ok", what);
        end else begin
            bad_count++;
            $display("%s: mismatch", what);
        end
    endtask

    task automatic check_reset_values();
        int err_before;
        err_before = errors;
        compare("target_split_ack", 32'(target_split_ack), 0);
        compare("target_ack", 32'(target_ack), 0);
        compare("target_data_out_valid", 32'(target_data_out_valid), 0);
        compare("split_req", 32'(split_req), 0);
        compare("init_req", 32'(init_req), 0);
        compare("init_addr_out_valid", 32'(init_addr_out_valid), 0);
        compare("init_data_out_valid", 32'(init_data_out_valid), 0);
        compare("init_rw", 32'(init_rw), 1);
        report_test("outputs after reset", err_before);
    endtask

    task automatic apply_row(input int idx);
        row_t              r;
        int                cycles;
        int                err_before;
        int                b_before;
        int                sa_at;
        int                sa_pulses;
        int                ack_at;
        int                data_at;
        int                data_pulses;
        int                grant_at;
        logic              saw_split;
        logic              saw_init_req;
        logic              done;
        bridge_pkg::data_t rdata;
        r = rows[idx];
        err_before = errors;
        b_before = b_count;
        cycles = 0;
        sa_at = 0;
        sa_pulses = 0;
        ack_at = 0;
        data_at = 0;
        data_pulses = 0;
        grant_at = 0;
        saw_split = 1'b0;
        saw_init_req = 1'b0;
        done = 1'b0;
        rdata = '0;
        @(posedge clk);
        target_addr_in <= r.a_addr;
        target_addr_in_valid <= 1'b1;
        target_rw <= r.rw;
        target_data_in <= r.late ? '0 : r.wdata;
        target_data_in_valid <= r.rw && !r.late;
        while (!done && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
            if (cycles == 1) begin
                target_addr_in_valid <= 1'b0;
                target_data_in_valid <= 1'b0;
            end
            if (r.late && cycles == LATE_SAMPLE) begin
                target_data_in <= r.wdata;
                target_data_in_valid <= 1'b1;
            end
            if (r.late && cycles == LATE_SAMPLE + 1) begin
                target_data_in_valid <= 1'b0;
            end
            if (split_req) begin
                saw_split = 1'b1;
            end
            if (init_req) begin
                saw_init_req = 1'b1;
            end
            if (split_grant && grant_at == 0) begin
                grant_at = cycles;
            end
            if (target_split_ack) begin
                sa_at = cycles;
                sa_pulses++;
            end
            if (target_data_out_valid) begin
                data_at = cycles;
                data_pulses++;
                rdata = target_data_out;
            end
            if (target_ack) begin
                ack_at = cycles;
                done = 1'b1;
            end
        end
        if (!done) begin
            $display("test %0d: no target_ack within %0d cycles", idx, TIMEOUT);
            errors++;
            timed_out = 1'b1;
        end else begin
            compare("target_split_ack pulses", sa_pulses, 1);
            compare("target_split_ack cycle", sa_at, ACCEPT_SAMPLE);
            compare("target_data_out_valid pulses", data_pulses, r.rw ? 0 : 1);
            compare("split_req", 32'(saw_split), 32'(r.split && !r.rw));
            if (!r.hit) begin
                compare("target_ack cycle", ack_at, ACCEPT_SAMPLE);
                compare("init_req", 32'(saw_init_req), 0);
                compare("bus B accesses", b_count - b_before, 0);
            end else begin
                compare("bus B accesses", b_count - b_before, 1);
                compare("init_addr_out", 32'(b_addr), 32'(r.b_addr));
                compare("init_rw", 32'(b_rw), 32'(r.rw));
                compare("init_addr_out_valid", 32'(b_addr_valid_held), 1);
                compare("init_data_out_valid", 32'(b_data_valid), 32'(r.rw));
                compare("init_req", 32'(b_req_held), 1);
            end
            if (r.hit && r.rw) begin
                compare("init_data_out", 32'(b_data), 32'(r.wdata));
            end
            if (!r.rw) begin
                compare("target_data_out", 32'(rdata), r.hit ? 32'(expected_read(idx)) : 0);
                compare("target_data_out_valid cycle", data_at, ack_at);
            end
            if (r.split && !r.rw) begin
                compare("target_data_out_valid cycle after split_grant", data_at, grant_at + 1);
            end
        end
        report_test($sformatf("test %0d %s 0x%04h", idx, r.rw ? "write" : "read", r.a_addr),
                    err_before);
    endtask

    initial begin : bus_b_responder
        int wait_cycles;
        logic data_first;
        init_grant = 1'b0;
        init_data_in = '0;
        init_data_in_valid = 1'b0;
        init_ack = 1'b0;
        init_split_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (rst_n && init_addr_out_valid) begin
                wait_cycles = $unsigned($random(seed)) % 4;
                b_addr_valid_held = 1'b1;
                repeat (wait_cycles) begin
                    @(posedge clk);
                    b_addr_valid_held &= init_addr_out_valid;
                end
                init_grant <= 1'b1;
                @(posedge clk);
                init_grant <= 1'b0;
                b_addr_valid_held &= init_addr_out_valid;
                b_data_valid = init_data_out_valid;
                b_req_held = init_req;
                b_addr = init_addr_out;
                b_rw = init_rw;
                if (init_rw) begin
                    b_data = init_data_out;
                    mem[init_addr_out] = init_data_out;
                    written[init_addr_out] = 1'b1;
                    init_ack <= 1'b1;
                    @(posedge clk);
                    init_ack <= 1'b0;
                end else begin
                    b_data = written[init_addr_out] ? mem[init_addr_out] : fill_byte(init_addr_out);
                    data_first = ($random(seed) & 1) != 0;
                    if (data_first) begin
                        data_first_count++;
                    end else begin
                        ack_first_count++;
                    end
                    init_data_in <= b_data;
                    init_data_in_valid <= data_first;
                    init_ack <= !data_first;
                    @(posedge clk);
                    init_data_in_valid <= !data_first;
                    init_ack <= data_first;
                    @(posedge clk);
                    init_data_in_valid <= 1'b0;
                    init_ack <= 1'b0;
                end
                b_count++;
            end
        end
    end

    // the bus A side grants a held split read two cycles after it shows up
    initial begin : split_granter
        split_grant = 1'b0;
        forever begin
            @(posedge clk);
            if (split_req) begin
                repeat (2) @(posedge clk);
                split_grant <= 1'b1;
                @(posedge clk);
                split_grant <= 1'b0;
            end
        end
    end

    initial begin : run_tests
        int err_before;
        rst_n = 1'b0;
        target_addr_in = '0;
        target_addr_in_valid = 1'b0;
        target_rw = 1'b0;
        target_data_in = '0;
        target_data_in_valid = 1'b0;
        // writes to every region with the data alongside the address
        rows.push_back(make_row(16'h8010, 1'b1, 8'hA1, 1'b0));
        rows.push_back(make_row(16'h87FF, 1'b1, 8'hA2, 1'b0));
        rows.push_back(make_row(16'h8800, 1'b1, 8'hB3, 1'b0));
        rows.push_back(make_row(16'h9234, 1'b1, 8'hB4, 1'b0));
        rows.push_back(make_row(16'h9800, 1'b1, 8'hC5, 1'b0));
        rows.push_back(make_row(16'hA7FF, 1'b1, 8'hC6, 1'b0));
        // the data follows the address by a few cycles
        rows.push_back(make_row(16'h8123, 1'b1, 8'h3C, 1'b1));
        rows.push_back(make_row(16'h9ABC, 1'b1, 8'h7E, 1'b1));
        // untouched bytes in regions 1 and 2, then region 0 behind split_req
        rows.push_back(make_row(16'h8C00, 1'b0, 8'h00, 1'b0));
        rows.push_back(make_row(16'hA000, 1'b0, 8'h00, 1'b0));
        rows.push_back(make_row(16'h8200, 1'b0, 8'h00, 1'b0));
        // below the window and at or above its end
        rows.push_back(make_row(16'h7FFF, 1'b1, 8'h11, 1'b0));
        rows.push_back(make_row(16'h7FFF, 1'b0, 8'h00, 1'b0));
        rows.push_back(make_row(16'h0000, 1'b0, 8'h00, 1'b0));
        rows.push_back(make_row(16'hA800, 1'b0, 8'h00, 1'b0));
        rows.push_back(make_row(16'hFFFF, 1'b1, 8'h22, 1'b0));
        // read back what was written
        rows.push_back(make_row(16'h8010, 1'b0, 8'h00, 1'b0));
        rows.push_back(make_row(16'h87FF, 1'b0, 8'h00, 1'b0));
        rows.push_back(make_row(16'h8800, 1'b0, 8'h00, 1'b0));
        rows.push_back(make_row(16'h9234, 1'b0, 8'h00, 1'b0));
        rows.push_back(make_row(16'h9800, 1'b0, 8'h00, 1'b0));
        rows.push_back(make_row(16'hA7FF, 1'b0, 8'h00, 1'b0));
        rows.push_back(make_row(16'h8123, 1'b0, 8'h00, 1'b0));
        rows.push_back(make_row(16'h9ABC, 1'b0, 8'h00, 1'b0));
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_reset_values();
        for (int i = 0; i < rows.size() && !timed_out; i++) begin
            apply_row(i);
        end
        // both orders of read data and init_ack have to be exercised
        err_before = errors;
        if (data_first_count == 0 || ack_first_count == 0) begin
            $display("read data never came on both sides of init_ack");
            errors++;
        end
        report_test("read data order", err_before);
        $display("%0d tests ok, %0d with mismatches, %0d errors, data first %0d, ack first %0d",
                 ok_count, bad_count, errors, data_first_count, ack_first_count);
        if (errors == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/bus_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module bus_bridge (
    input  wire logic              clk,
    input  wire logic              rst_n,
    // the bridge is a target on bus A
    input  wire bridge_pkg::addr_t target_addr_in,
    input  wire logic              target_addr_in_valid,
    input  wire logic              target_rw,
    input  wire bridge_pkg::data_t target_data_in,
    input  wire logic              target_data_in_valid,
    input  wire logic              split_grant,
    output logic                   target_split_ack,
    output logic                   target_ack,
    output bridge_pkg::data_t      target_data_out,
    output logic                   target_data_out_valid,
    output logic                   split_req,
    // the bridge initiates on bus B
    output logic                   init_req,
    output bridge_pkg::addr_t      init_addr_out,
    output logic                   init_addr_out_valid,
    output bridge_pkg::data_t      init_data_out,
    output logic                   init_data_out_valid,
    output logic                   init_rw,
    input  wire logic              init_grant,
    input  wire bridge_pkg::data_t init_data_in,
    input  wire logic              init_data_in_valid,
    input  wire logic              init_ack,
    input  wire logic              init_split_ack
);

    logic              dec_valid;
    logic              dec_hit;
    logic              dec_split;
    bridge_pkg::addr_t dec_addr;
    logic              dec_rw;
    bridge_pkg::data_t dec_data;
    logic              dec_data_valid;

    logic              req_valid;
    logic              req_ready;
    logic              req_write;
    bridge_pkg::addr_t req_addr;
    bridge_pkg::data_t req_data;
    logic              resp_valid;
    logic              resp_ready;
    logic              resp_write;
    bridge_pkg::data_t resp_data;

    addr_decode i_decode (
        .clk                  (clk),
        .rst_n                (rst_n),
        .target_addr_in       (target_addr_in),
        .target_addr_in_valid (target_addr_in_valid),
        .target_rw            (target_rw),
        .target_data_in       (target_data_in),
        .target_data_in_valid (target_data_in_valid),
        .dec_valid            (dec_valid),
        .dec_hit              (dec_hit),
        .dec_split            (dec_split),
        .dec_addr             (dec_addr),
        .dec_rw               (dec_rw),
        .dec_data             (dec_data),
        .dec_data_valid       (dec_data_valid)
    );

    target_port i_target (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .dec_valid             (dec_valid),
        .dec_hit               (dec_hit),
        .dec_split             (dec_split),
        .dec_addr              (dec_addr),
        .dec_rw                (dec_rw),
        .dec_data              (dec_data),
        .dec_data_valid        (dec_data_valid),
        .target_data_in        (target_data_in),
        .target_data_in_valid  (target_data_in_valid),
        .split_grant           (split_grant),
        .target_split_ack      (target_split_ack),
        .target_ack            (target_ack),
        .target_data_out       (target_data_out),
        .target_data_out_valid (target_data_out_valid),
        .split_req             (split_req),
        .req_valid             (req_valid),
        .req_ready             (req_ready),
        .req_write             (req_write),
        .req_addr              (req_addr),
        .req_data              (req_data),
        .resp_valid            (resp_valid),
        .resp_ready            (resp_ready),
        .resp_write            (resp_write),
        .resp_data             (resp_data)
    );

    initiator_port i_initiator (
        .clk                 (clk),
        .rst_n               (rst_n),
        .req_valid           (req_valid),
        .req_ready           (req_ready),
        .req_write           (req_write),
        .req_addr            (req_addr),
        .req_data            (req_data),
        .resp_valid          (resp_valid),
        .resp_ready          (resp_ready),
        .resp_write          (resp_write),
        .resp_data           (resp_data),
        .init_req            (init_req),
        .init_addr_out       (init_addr_out),
        .init_addr_out_valid (init_addr_out_valid),
        .init_data_out       (init_data_out),
        .init_data_out_valid (init_data_out_valid),
        .init_rw             (init_rw),
        .init_grant          (init_grant),
        .init_data_in        (init_data_in),
        .init_data_in_valid  (init_data_in_valid),
        .init_ack            (init_ack),
        .init_split_ack      (init_split_ack)
    );

endmodule

`default_nettype wire

//--- hdl/initiator_port.sv
`timescale 1ns/1ps
`default_nettype none

module initiator_port (
    input  wire logic              clk,
    input  wire logic              rst_n,
    // request from the target side
    input  wire logic              req_valid,
    output logic                   req_ready,
    input  wire logic              req_write,
    input  wire bridge_pkg::addr_t req_addr,
    input  wire bridge_pkg::data_t req_data,
    // response back to the target side
    output logic                   resp_valid,
    input  wire logic              resp_ready,
    output logic                   resp_write,
    output bridge_pkg::data_t      resp_data,
    // bus B
    output logic                   init_req,
    output bridge_pkg::addr_t      init_addr_out,
    output logic                   init_addr_out_valid,
    output bridge_pkg::data_t      init_data_out,
    output logic                   init_data_out_valid,
    output logic                   init_rw,
    input  wire logic              init_grant,
    input  wire bridge_pkg::data_t init_data_in,
    input  wire logic              init_data_in_valid,
    input  wire logic              init_ack,
    input  wire logic              init_split_ack
);

    bridge_pkg::init_state_t state;

    bridge_pkg::addr_t cur_addr;
    bridge_pkg::data_t cur_data;
    bridge_pkg::data_t rd_buf;
    logic              ack_seen;
    logic              rd_seen;
    logic              active;
    logic              done;

    assign active = (state == bridge_pkg::INIT_SEND) || (state == bridge_pkg::INIT_WAIT_ACK);

    // read data can come before, with or after the ack
    assign done = (ack_seen || init_ack) && (init_rw || rd_seen || init_data_in_valid);

    assign req_ready     = (state == bridge_pkg::INIT_IDLE);
    assign resp_valid    = (state == bridge_pkg::INIT_RESP_HOLD);
    assign resp_write    = init_rw;
    assign resp_data     = init_rw ? '0 : rd_buf;
    assign init_addr_out = cur_addr;
    assign init_data_out = cur_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state               <= bridge_pkg::INIT_IDLE;
            init_req            <= 1'b0;
            init_addr_out_valid <= 1'b0;
            init_data_out_valid <= 1'b0;
            init_rw             <= 1'b1;
            ack_seen            <= 1'b0;
            rd_seen             <= 1'b0;
        end else begin
            if (active) begin
                if (init_data_in_valid) begin
                    rd_seen <= 1'b1;
                end
                if (init_ack) begin
                    ack_seen <= 1'b1;
                end
                // a split ack releases the bus, the data follows later
                if (init_ack || init_split_ack) begin
                    init_req <= 1'b0;
                end
            end

            case (state)
                bridge_pkg::INIT_IDLE: begin
                    if (req_valid) begin
                        init_req            <= 1'b1;
                        init_rw             <= req_write;
                        init_addr_out_valid <= 1'b1;
                        init_data_out_valid <= req_write;
                        ack_seen            <= 1'b0;
                        rd_seen             <= 1'b0;
                        state               <= bridge_pkg::INIT_SEND;
                    end
                end

                bridge_pkg::INIT_SEND: begin
                    if (init_grant) begin
                        init_addr_out_valid <= 1'b0;
                        init_data_out_valid <= 1'b0;
                        state               <= bridge_pkg::INIT_WAIT_ACK;
                    end
                end

                bridge_pkg::INIT_WAIT_ACK: begin
                    if (done) begin
                        state <= bridge_pkg::INIT_RESP_HOLD;
                    end
                end

                bridge_pkg::INIT_RESP_HOLD: begin
                    if (resp_ready) begin
                        state <= bridge_pkg::INIT_IDLE;
                    end
                end

                default: state <= bridge_pkg::INIT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == bridge_pkg::INIT_IDLE) && req_valid) begin
            cur_addr <= req_addr;
            cur_data <= req_data;
        end
        if (active && init_data_in_valid) begin
            rd_buf <= init_data_in;
        end
    end

endmodule

`default_nettype wire

//--- hdl/target_port.sv
`timescale 1ns/1ps
`default_nettype none

module target_port (
    input  wire logic              clk,
    input  wire logic              rst_n,
    // decoded access from the first stage
    input  wire logic              dec_valid,
    input  wire logic              dec_hit,
    input  wire logic              dec_split,
    input  wire bridge_pkg::addr_t dec_addr,
    input  wire logic              dec_rw,
    input  wire bridge_pkg::data_t dec_data,
    input  wire logic              dec_data_valid,
    // bus A
    input  wire bridge_pkg::data_t target_data_in,
    input  wire logic              target_data_in_valid,
    input  wire logic              split_grant,
    output logic                   target_split_ack,
    output logic                   target_ack,
    output bridge_pkg::data_t      target_data_out,
    output logic                   target_data_out_valid,
    output logic                   split_req,
    // request to the initiator
    output logic                   req_valid,
    input  wire logic              req_ready,
    output logic                   req_write,
    output bridge_pkg::addr_t      req_addr,
    output bridge_pkg::data_t      req_data,
    // response from the initiator
    input  wire logic              resp_valid,
    output logic                   resp_ready,
    input  wire logic              resp_write,
    input  wire bridge_pkg::data_t resp_data
);

    bridge_pkg::target_state_t state;

    bridge_pkg::addr_t cur_addr;
    bridge_pkg::data_t cur_wdata;
    bridge_pkg::data_t rd_hold;
    logic              cur_write;
    logic              cur_split;
    logic              accept;
    logic              need_wdata;

    assign accept = (state == bridge_pkg::TGT_IDLE) && dec_valid;

    // write data may also turn up on bus A one cycle after the address
    assign need_wdata = dec_rw && !dec_data_valid && !target_data_in_valid;

    assign req_valid  = (state == bridge_pkg::TGT_SEND_REQ);
    assign req_write  = cur_write;
    assign req_addr   = cur_addr;
    assign req_data   = cur_wdata;
    assign resp_ready = (state == bridge_pkg::TGT_WAIT_RESP);
    assign split_req  = (state == bridge_pkg::TGT_WAIT_GRANT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state                 <= bridge_pkg::TGT_IDLE;
            target_split_ack      <= 1'b0;
            target_ack            <= 1'b0;
            target_data_out_valid <= 1'b0;
        end else begin
            target_split_ack      <= 1'b0;
            target_ack            <= 1'b0;
            target_data_out_valid <= 1'b0;

            case (state)
                bridge_pkg::TGT_IDLE: begin
                    if (dec_valid) begin
                        target_split_ack <= 1'b1;
                        if (!dec_hit) begin
                            // outside the window, answered here without touching bus B
                            target_ack            <= 1'b1;
                            target_data_out_valid <= !dec_rw;
                        end else if (need_wdata) begin
                            state <= bridge_pkg::TGT_WAIT_WDATA;
                        end else begin
                            state <= bridge_pkg::TGT_SEND_REQ;
                        end
                    end
                end

                bridge_pkg::TGT_WAIT_WDATA: begin
                    if (target_data_in_valid) begin
                        state <= bridge_pkg::TGT_SEND_REQ;
                    end
                end

                bridge_pkg::TGT_SEND_REQ: begin
                    if (req_ready) begin
                        state <= bridge_pkg::TGT_WAIT_RESP;
                    end
                end

                bridge_pkg::TGT_WAIT_RESP: begin
                    if (resp_valid) begin
                        if (resp_write) begin
                            target_ack <= 1'b1;
                            state      <= bridge_pkg::TGT_IDLE;
                        end else if (cur_split) begin
                            state <= bridge_pkg::TGT_WAIT_GRANT;
                        end else begin
                            target_data_out_valid <= 1'b1;
                            target_ack            <= 1'b1;
                            state                 <= bridge_pkg::TGT_IDLE;
                        end
                    end
                end

                bridge_pkg::TGT_WAIT_GRANT: begin
                    if (split_grant) begin
                        target_data_out_valid <= 1'b1;
                        target_ack            <= 1'b1;
                        state                 <= bridge_pkg::TGT_IDLE;
                    end
                end

                default: state <= bridge_pkg::TGT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cur_addr  <= dec_addr;
            cur_write <= dec_rw;
            cur_split <= dec_split;
            cur_wdata <= dec_data_valid ? dec_data : target_data_in;
        end
        if ((state == bridge_pkg::TGT_WAIT_WDATA) && target_data_in_valid) begin
            cur_wdata <= target_data_in;
        end

        if (resp_valid && resp_ready) begin
            rd_hold <= resp_data;
        end

        if (accept && !dec_hit) begin
            target_data_out <= '0;
        end else if (resp_valid && resp_ready && !cur_split) begin
            target_data_out <= resp_data;
        end else if ((state == bridge_pkg::TGT_WAIT_GRANT) && split_grant) begin
            target_data_out <= rd_hold;
        end
    end

endmodule

`default_nettype wire

//--- hdl/addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_cfg.svh"

module addr_decode (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire bridge_pkg::addr_t target_addr_in,
    input  wire logic              target_addr_in_valid,
    input  wire logic              target_rw,
    input  wire bridge_pkg::data_t target_data_in,
    input  wire logic              target_data_in_valid,
    output logic                   dec_valid,
    output logic                   dec_hit,
    output logic                   dec_split,
    output bridge_pkg::addr_t      dec_addr,
    output logic                   dec_rw,
    output bridge_pkg::data_t      dec_data,
    output logic                   dec_data_valid
);

    localparam bridge_pkg::addr_t WIN_BASE = `BRIDGE_BASE_ADDR;
    localparam bridge_pkg::addr_t R0_END   = `REGION0_SIZE;
    localparam bridge_pkg::addr_t R1_END   = `REGION0_SIZE + `REGION1_SIZE;
    localparam bridge_pkg::addr_t WIN_SIZE = `REGION0_SIZE + `REGION1_SIZE + `REGION2_SIZE;

    bridge_pkg::addr_t offset;
    bridge_pkg::addr_t b_addr;
    logic              in_window;
    logic              in_r0;

    // the subtraction wraps below the base, so the lower bound is checked separately
    assign offset    = target_addr_in - WIN_BASE;
    assign in_window = (target_addr_in >= WIN_BASE) && (offset < WIN_SIZE);
    assign in_r0     = offset < R0_END;

    always_comb begin
        if (in_r0) begin
            b_addr = `REGION0_B_BASE + offset;
        end else if (offset < R1_END) begin
            b_addr = `REGION1_B_BASE + (offset - R0_END);
        end else begin
            b_addr = `REGION2_B_BASE + (offset - R1_END);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid      <= 1'b0;
            dec_data_valid <= 1'b0;
        end else begin
            dec_valid      <= target_addr_in_valid;
            dec_data_valid <= target_data_in_valid;
        end
    end

    always_ff @(posedge clk) begin
        dec_hit   <= in_window;
        dec_split <= in_window && in_r0;
        dec_addr  <= b_addr;
        dec_rw    <= target_rw;
        dec_data  <= target_data_in;
    end

endmodule

`default_nettype wire

//--- hdl/bridge_pkg.sv
`default_nettype none

`include "bridge_cfg.svh"

package bridge_pkg;

    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [`DATA_W-1:0] data_t;

    typedef enum logic [2:0] {
        TGT_IDLE,
        TGT_WAIT_WDATA,
        TGT_SEND_REQ,
        TGT_WAIT_RESP,
        TGT_WAIT_GRANT
    } target_state_t;

    typedef enum logic [1:0] {
        INIT_IDLE,
        INIT_SEND,
        INIT_WAIT_ACK,
        INIT_RESP_HOLD
    } init_state_t;

endpackage

`default_nettype wire

//--- include/bridge_cfg.svh
`ifndef BRIDGE_CFG_SVH
`define BRIDGE_CFG_SVH

// both buses share the same address and data widths
`define ADDR_W 16
`define DATA_W 8

// the bus A window starts here and the three regions follow each other
`define BRIDGE_BASE_ADDR 16'h8000

`define REGION0_SIZE 16'd2048
`define REGION1_SIZE 16'd4096
`define REGION2_SIZE 16'd4096

// where each region lands on bus B
`define REGION0_B_BASE 16'h0000
`define REGION1_B_BASE 16'h4000
`define REGION2_B_BASE 16'h8000

`endif
